// File: hdl/vga_timing_pkg.sv
package vga_timing_pkg;

  // ------------------------------------------------------------
  // 640x480 VGA raster, one position per clock
  // ------------------------------------------------------------

  // Horizontal geometry in pixel clocks
  localparam logic [9:0] h_visible = 10'd640;
  localparam logic [9:0] h_front   = 10'd16;
  localparam logic [9:0] h_sync    = 10'd96;
  localparam logic [9:0] h_back    = 10'd48;
  localparam logic [9:0] h_total   = h_visible + h_front + h_sync + h_back;

  // Vertical geometry in scanlines
  localparam logic [9:0] v_visible = 10'd480;
  localparam logic [9:0] v_front   = 10'd10;
  localparam logic [9:0] v_sync    = 10'd2;
  localparam logic [9:0] v_back    = 10'd33;
  localparam logic [9:0] v_total   = v_visible + v_front + v_sync + v_back;

  typedef logic [9:0] hpos_t;
  typedef logic [9:0] vpos_t;

  // ------------------------------------------------------------
  // Source line, each source pixel is 4x2 VGA pixels
  // ------------------------------------------------------------
  typedef logic [7:0] src_xpos_t;
  typedef logic [8:0] src_ypos_t;

  localparam src_xpos_t src_width        = 8'd160;
  localparam src_ypos_t stall_first_line = 9'd36;
  localparam int        px_shift         = 2;

endpackage

// File: hdl/video_color_pkg.sv
package video_color_pkg;

  // ------------------------------------------------------------
  // Pixel and colour words
  // ------------------------------------------------------------

  // Source pixel, hue in the upper nibble
  typedef struct packed {
    logic [3:0] hue;
    logic [2:0] luma;
  } pixel_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb24_t;

  // Output levels for the 2-bit-per-channel DAC
  typedef struct packed {
    logic [1:0] r;
    logic [1:0] g;
    logic [1:0] b;
  } rgb2_t;

  // Base colour of each hue at full luma
  localparam rgb24_t hue_table [16] = '{
    24'hffffff, 24'hfcfc68, 24'hece078, 24'hfcbc94,
    24'hfcb4b4, 24'hecb0e0, 24'hd4b0fc, 24'hbcb4fc,
    24'ha4c8fc, 24'ha4e0fc, 24'ha4fcd4, 24'hb8fcb8,
    24'hc8fca4, 24'he0ec9c, 24'hfce08c, 24'hfcd4a8
  };

  // ------------------------------------------------------------
  // Control register map
  // ------------------------------------------------------------
  localparam logic [3:0] reg_ctrl_addr   = 4'h0;
  localparam logic [3:0] reg_status_addr = 4'h4;

  typedef struct packed {
    logic [5:0] reserved;
    logic       video_en;
    logic       dither_en;
  } ctrl_reg_t;

  localparam logic [1:0] axil_resp_okay   = 2'b00;
  localparam logic [1:0] axil_resp_slverr = 2'b10;

endpackage

// File: hdl/vga_pos_if.sv
`timescale 1ns/1ps

// Raster position and syncs, all from the same clock edge
interface vga_pos_if;

  logic [9:0] hpos;
  logic [9:0] vpos;
  logic       display_on;
  logic       hsync;
  logic       vsync;

  // Timing generator side
  modport src (output hpos, vpos, display_on, hsync, vsync);
  // Consumers of the scan position
  modport dst (input hpos, vpos, display_on, hsync, vsync);

endinterface

// File: hdl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing import vga_timing_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  vga_pos_if.src    pos
);

  hpos_t h_cnt;
  vpos_t v_cnt;
  hpos_t h_next;
  vpos_t v_next;
  logic  hs_r;
  logic  vs_r;
  logic  de_r;

  // Next position, wrap at the end of line and frame
  always_comb begin
    h_next = (h_cnt == h_total - 10'd1) ? '0 : h_cnt + 10'd1;
    v_next = v_cnt;
    if (h_cnt == h_total - 10'd1) begin
      v_next = (v_cnt == v_total - 10'd1) ? '0 : v_cnt + 10'd1;
    end
  end

  // Syncs decoded from the next position so they line up with the counters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
      hs_r  <= 1'b1;
      vs_r  <= 1'b1;
      de_r  <= 1'b1;
    end else begin
      h_cnt <= h_next;
      v_cnt <= v_next;
      // Both syncs active low
      hs_r  <= !(h_next >= h_visible + h_front && h_next < h_total - h_back);
      vs_r  <= !(v_next >= v_visible + v_front && v_next < v_total - v_back);
      de_r  <= (h_next < h_visible) && (v_next < v_visible);
    end
  end

  assign pos.hpos       = h_cnt;
  assign pos.vpos       = v_cnt;
  assign pos.hsync      = hs_r;
  assign pos.vsync      = vs_r;
  assign pos.display_on = de_r;

endmodule

// File: hdl/scan_line_buffer.sv
`timescale 1ns/1ps

module scan_line_buffer import vga_timing_pkg::*, video_color_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  src_xpos_t src_xpos,
  input  src_ypos_t src_ypos,
  input  pixel_t    src_pixel,
  input  logic      src_valid,
  vga_pos_if.dst    pos,
  output pixel_t    rd_pixel,
  output logic      src_stall
);

  // One source line
  pixel_t line_mem [src_width];
  hpos_t  rd_col;
  logic   src_write;

  assign src_write = src_valid && (src_xpos < src_width);

  // Four VGA columns per source pixel
  assign rd_col = pos.hpos >> px_shift;

  always_ff @(posedge clk) begin
    if (src_write) begin
      line_mem[src_xpos] <= src_pixel;
    end
  end

  // Registered read, black past the end of the source line
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pixel <= '0;
    end else if (rd_col < hpos_t'(src_width)) begin
      rd_pixel <= line_mem[rd_col[7:0]];
    end else begin
      rd_pixel <= '0;
    end
  end

  // Hold the source while it is more than a line pair ahead of the scan
  assign src_stall = (src_ypos > stall_first_line) && (pos.vpos < {src_ypos, 1'b0});

endmodule

// File: hdl/ntsc_palette.sv
`timescale 1ns/1ps

module ntsc_palette import video_color_pkg::*; (
  input  pixel_t pixel,
  output rgb24_t color
);

  rgb24_t     base;
  logic [3:0] gain;

  // Scale one channel by gain/8
  function automatic logic [7:0] scale_chan(input logic [7:0] c, input logic [3:0] m);
    logic [11:0] prod;
    prod = c * m;
    return prod[10:3];
  endfunction

  // ------------------------------------------------------------
  // Hue picks the base colour, luma sets the brightness
  // ------------------------------------------------------------
  assign base = hue_table[pixel.hue];

  // Luma 0..7 maps to 1/8..8/8 of the base
  assign gain = {1'b0, pixel.luma} + 4'd1;

  // Full luma returns the table entry itself
  assign color.r = scale_chan(base.r, gain);
  assign color.g = scale_chan(base.g, gain);
  assign color.b = scale_chan(base.b, gain);

endmodule

// File: hdl/pwm_dither.sv
`timescale 1ns/1ps

module pwm_dither import vga_timing_pkg::*, video_color_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  vga_pos_if.dst     pos,
  input  rgb24_t     color,
  input  logic       src_vsync,
  input  logic       src_vblank,
  input  logic       dither_en,
  input  logic       video_en,
  output logic [2:0] phase,
  output logic       hsync,
  output logic       vsync,
  output rgb2_t      rgb
);

  logic             vsync_last;
  logic [px_shift-1:0] h_lo_d1;
  logic             h0_d1;
  logic             v0_d1;
  logic             de_d1;
  logic             hs_d1;
  logic             vs_d1;
  logic             restart;
  logic             row_sel;
  logic [7:0]       chan [3];
  logic [9:0]       tri3 [3];
  logic [9:0]       odd_next [3];
  logic [9:0]       even_next [3];
  logic [9:0]       acc_odd [3];
  logic [9:0]       acc_even [3];
  logic [1:0]       lvl [3];

  // Horizontal error carry, dropped at each pixel onset
  function automatic logic [9:0] carry(input logic [9:0] acc, input logic clr);
    return clr ? 10'd0 : ((acc & 10'h0ff) >> 1);
  endfunction

  assign chan[0] = color.r;
  assign chan[1] = color.g;
  assign chan[2] = color.b;

  // Phase bits 2:1 pick the pixel onset column, bit 0 the onset row
  assign restart = h0_d1 || (h_lo_d1 == phase[2:1]);
  assign row_sel = (v0_d1 == phase[0]);

  always_comb begin
    for (int i = 0; i < 3; i++) begin
      tri3[i]      = {2'b00, chan[i]} * 10'd3;
      odd_next[i]  = carry(acc_odd[i], restart) + tri3[i];
      // Second row also takes the low byte of the first as vertical carry
      even_next[i] = carry(acc_even[i], restart) + tri3[i] + (odd_next[i] & 10'h0ff);
      if (!dither_en) lvl[i] = chan[i][7:6];
      else lvl[i] = row_sel ? odd_next[i][9:8] : even_next[i][9:8];
    end
  end

  // ------------------------------------------------------------
  // Frame phase, position delay, accumulators and output register
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vsync_last <= 1'b0;
      phase      <= '0;
      {h_lo_d1, h0_d1, v0_d1, de_d1} <= '0;
      {hs_d1, vs_d1, hsync, vsync}   <= '1;
      rgb        <= '0;
      for (int i = 0; i < 3; i++) begin
        acc_odd[i]  <= '0;
        acc_even[i] <= '0;
      end
    end else begin
      vsync_last <= src_vsync;
      // Column phase steps 0,1,3,2 while the row phase toggles
      if (src_vsync && !vsync_last) begin
        phase <= {phase[1], !phase[2], !phase[0]};
      end
      // Align the position with the registered line buffer read
      h_lo_d1 <= pos.hpos[px_shift-1:0];
      h0_d1   <= (pos.hpos == '0);
      v0_d1   <= pos.vpos[0];
      de_d1   <= pos.display_on;
      hs_d1   <= pos.hsync;
      vs_d1   <= pos.vsync;
      hsync   <= hs_d1;
      vsync   <= vs_d1;
      for (int i = 0; i < 3; i++) begin
        acc_odd[i]  <= odd_next[i];
        acc_even[i] <= even_next[i];
      end
      if (de_d1 && !src_vblank && video_en) rgb <= {lvl[0], lvl[1], lvl[2]};
      else rgb <= '0;
    end
  end

endmodule

// File: hdl/video_ctrl_regs.sv
`timescale 1ns/1ps

module video_ctrl_regs import video_color_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  input  logic [2:0]  phase,
  output logic        dither_en,
  output logic        video_en
);

  ctrl_reg_t ctrl;
  logic      wr_accept;
  logic      rd_accept;

  // Ready is a one-cycle pulse, so acceptance is ready with valid
  assign wr_accept = awready && awvalid && wvalid;
  assign rd_accept = arready && arvalid;

  // ------------------------------------------------------------
  // Write channel, address and data taken together
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bresp   <= axil_resp_okay;
      ctrl    <= 8'h03;
    end else begin
      // No new write while a response is still held
      awready <= !awready && awvalid && wvalid && !bvalid;
      wready  <= !awready && awvalid && wvalid && !bvalid;
      if (wr_accept) begin
        bvalid <= 1'b1;
        bresp  <= axil_resp_okay;
        if (awaddr == reg_ctrl_addr && wstrb[0]) ctrl <= wdata[7:0];
        else if (awaddr != reg_ctrl_addr && awaddr != reg_status_addr) bresp <= axil_resp_slverr;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Read channel
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
      rresp   <= axil_resp_okay;
    end else begin
      arready <= !arready && arvalid && !rvalid;
      if (rd_accept) begin
        rvalid <= 1'b1;
        rresp  <= axil_resp_okay;
        rdata  <= '0;
        if (araddr == reg_ctrl_addr) rdata <= {24'd0, ctrl};
        else if (araddr == reg_status_addr) rdata <= {29'd0, phase};
        else rresp <= axil_resp_slverr;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  assign dither_en = ctrl.dither_en;
  assign video_en  = ctrl.video_en;

endmodule

// File: hdl/atari_vga_bridge.sv
`timescale 1ns/1ps

module atari_vga_bridge import vga_timing_pkg::*, video_color_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  // Source video
  input  src_xpos_t   src_xpos,
  input  src_ypos_t   src_ypos,
  input  pixel_t      src_pixel,
  input  logic        src_valid,
  input  logic        src_vblank,
  input  logic        src_vsync,
  output logic        src_stall,
  // VGA
  output logic        vga_hsync,
  output logic        vga_vsync,
  output logic [1:0]  vga_r,
  output logic [1:0]  vga_g,
  output logic [1:0]  vga_b,
  // AXI4-Lite control
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  pixel_t     rd_pixel;
  rgb24_t     color;
  rgb2_t      vid_rgb;
  logic [2:0] phase;
  logic       dither_en;
  logic       video_en;

  // ------------------------------------------------------------
  // Scan position shared by the line buffer and the dither stage
  // ------------------------------------------------------------
  vga_pos_if vga_pos ();

  vga_timing u_timing (.clk(clk), .rst_n(rst_n), .pos(vga_pos.src));

  scan_line_buffer u_line (
    .clk(clk), .rst_n(rst_n), .src_xpos(src_xpos), .src_ypos(src_ypos),
    .src_pixel(src_pixel), .src_valid(src_valid), .pos(vga_pos.dst),
    .rd_pixel(rd_pixel), .src_stall(src_stall)
  );

  ntsc_palette u_palette (.pixel(rd_pixel), .color(color));

  // Output register stage, syncs delayed to match
  pwm_dither u_dither (
    .clk(clk), .rst_n(rst_n), .pos(vga_pos.dst), .color(color),
    .src_vsync(src_vsync), .src_vblank(src_vblank), .dither_en(dither_en),
    .video_en(video_en), .phase(phase), .hsync(vga_hsync), .vsync(vga_vsync),
    .rgb(vid_rgb)
  );

  video_ctrl_regs u_regs (
    .clk(clk), .rst_n(rst_n),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .phase(phase), .dither_en(dither_en), .video_en(video_en)
  );

  assign vga_r = vid_rgb.r;
  assign vga_g = vid_rgb.g;
  assign vga_b = vid_rgb.b;

endmodule

// File: verif/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Test kinds
localparam logic [1:0] kind_sync  = 2'd0;
localparam logic [1:0] kind_line  = 2'd1;
localparam logic [1:0] kind_regs  = 2'd2;
localparam logic [1:0] kind_stall = 2'd3;

// Pixel patterns written into the line buffer
localparam logic [1:0] pat_random = 2'd0;
localparam logic [1:0] pat_black  = 2'd1;
localparam logic [1:0] pat_white  = 2'd2;

// Expected colour rule on the checked scanline
localparam logic [1:0] rule_palette = 2'd0;
localparam logic [1:0] rule_zero    = 2'd1;
localparam logic [1:0] rule_nonzero = 2'd2;

typedef struct packed {
  logic [1:0] kind;
  logic [7:0] ctrl;
  logic [1:0] pattern;
  logic       vblank;
  logic [9:0] line;
  logic [1:0] rule;
} test_vec_t;

localparam int num_tests = 9;

// Columns: kind, control value, pattern, src_vblank, checked line, rule
// Dither lines are even, so with row phase 0 the first-row accumulator drives them
localparam test_vec_t test_table [num_tests] = '{
  '{kind_sync,  8'h03, pat_random, 1'b0, 10'd0,   rule_zero},
  '{kind_line,  8'h02, pat_random, 1'b0, 10'd60,  rule_palette},
  '{kind_line,  8'h02, pat_random, 1'b0, 10'd301, rule_palette},
  '{kind_line,  8'h03, pat_random, 1'b1, 10'd200, rule_zero},
  '{kind_line,  8'h01, pat_random, 1'b0, 10'd120, rule_zero},
  '{kind_line,  8'h03, pat_black,  1'b0, 10'd100, rule_zero},
  '{kind_line,  8'h03, pat_white,  1'b0, 10'd240, rule_nonzero},
  '{kind_regs,  8'h03, pat_random, 1'b0, 10'd0,   rule_zero},
  '{kind_stall, 8'h03, pat_random, 1'b0, 10'd0,   rule_zero}
};

// src_ypos values for the stall compare, all sampled on one raster line
localparam int        num_stall  = 7;
localparam vpos_t     stall_line = 10'd100;
localparam src_ypos_t stall_ypos [num_stall] = '{
  9'd20, 9'd36, 9'd37, 9'd49, 9'd50, 9'd51, 9'd200
};

// Expected src_stall on stall_line for each row above
// Row 36 is not past the first stall row, rows up to 50 are not ahead of line 100
localparam logic      stall_want [num_stall] = '{
  1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1
};

`endif

// File: verif/tb_atari_vga_bridge.sv
`timescale 1ns/1ps

module tb_atari_vga_bridge import vga_timing_pkg::*, video_color_pkg::*; ();

  `include "tb_vectors.svh"

  localparam int frame_cycles = int'(h_total) * int'(v_total);
  // From an hsync fall to column 0 of the next line
  localparam int line_lead = int'(h_sync) + int'(h_back);

  logic        clk;
  logic        rst_n;
  src_xpos_t   src_xpos;
  src_ypos_t   src_ypos;
  pixel_t      src_pixel;
  logic        src_valid;
  logic        src_vblank;
  logic        src_vsync;
  logic        src_stall;
  logic        vga_hsync;
  logic        vga_vsync;
  logic [1:0]  vga_r;
  logic [1:0]  vga_g;
  logic [1:0]  vga_b;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  // Copy of the source line last written
  pixel_t      line_data [160];
  int          errors;
  int          tests_ok;
  int          tests_bad;
  int          vsync_edges;

  atari_vga_bridge dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Two frames per test is more than any single test needs
  initial begin
    repeat (num_tests * 2 * frame_cycles + 20000) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d frames", num_tests * 2);
    $display("TEST FAIL");
    $finish;
  end

  task automatic report_error(input string msg);
    $display("FAILED %0t: %s", $time, msg);
    errors++;
  endtask

  // ------------------------------------------------------------
  // Raster tracking on the VGA outputs, sampled at falling edges
  // ------------------------------------------------------------
  task automatic wait_hsync_fall();
    logic prev;
    prev = vga_hsync;
    @(negedge clk);
    while (!(prev && !vga_hsync)) begin
      prev = vga_hsync;
      @(negedge clk);
    end
  endtask

  task automatic wait_vsync_edge(input logic level);
    logic prev;
    prev = vga_vsync;
    @(negedge clk);
    while (!(prev != level && vga_vsync == level)) begin
      prev = vga_vsync;
      @(negedge clk);
    end
  endtask

  // Returns on the hsync fall that leads into line n
  task automatic wait_line(input int n);
    wait_vsync_edge(1'b1);
    // First fall after the sync pulse is in the first back porch line
    repeat (int'(v_back) + n) wait_hsync_fall();
  endtask

  task automatic write_line(input logic [1:0] pattern);
    for (int x = 0; x < 160; x++) begin
      case (pattern)
        pat_black: line_data[x] = {4'd0, 3'd0};
        pat_white: line_data[x] = {4'd0, 3'd7};
        default:   line_data[x] = 7'($urandom_range(0, 127));
      endcase
    end
    for (int x = 0; x < 160; x++) begin
      @(negedge clk);
      src_xpos  = src_xpos_t'(x);
      src_pixel = line_data[x];
      src_valid = 1'b1;
    end
    @(negedge clk);
    src_valid = 1'b0;
  endtask

  // Channel times (luma + 1) / 8, then the top two bits of the 8-bit result
  function automatic logic [5:0] plain_levels(input pixel_t p);
    rgb24_t      base;
    logic [10:0] gain;
    logic [10:0] r;
    logic [10:0] g;
    logic [10:0] b;
    base = hue_table[p.hue];
    gain = 11'(p.luma) + 11'd1;
    r = (11'(base.r) * gain) >> 3;
    g = (11'(base.g) * gain) >> 3;
    b = (11'(base.b) * gain) >> 3;
    return {r[7:6], g[7:6], b[7:6]};
  endfunction

  // Column phase runs 0,1,3,2 and the row phase toggles each source frame
  function automatic logic [2:0] expected_phase(input int n);
    logic [1:0] col;
    case (n % 4)
      0:       col = 2'd0;
      1:       col = 2'd1;
      2:       col = 2'd3;
      default: col = 2'd2;
    endcase
    return {col, n[0]};
  endfunction

  // Walks one full line starting at the hsync fall
  task automatic check_line(input logic [1:0] rule);
    logic [5:0] got;
    logic [5:0] want;
    int         c;
    for (int k = 1; k < int'(h_total); k++) begin
      @(negedge clk);
      got = {vga_r, vga_g, vga_b};
      c   = k - line_lead;
      if ($isunknown(got)) begin
        report_error($sformatf("colour output unknown at column %0d", c));
      end else if (c < 0 || c >= int'(h_visible)) begin
        if (got != 6'd0) report_error($sformatf("blank column %0d shows %h", c, got));
      end else if (rule == rule_palette) begin
        want = plain_levels(line_data[c >> px_shift]);
        if (got != want) report_error($sformatf("column %0d got %h want %h", c, got, want));
      end else if (rule == rule_zero) begin
        if (got != 6'd0) report_error($sformatf("column %0d not black, got %h", c, got));
      end else begin
        if (vga_r == 2'd0 || vga_g == 2'd0 || vga_b == 2'd0) begin
          report_error($sformatf("column %0d has a zero level, got %h", c, got));
        end
      end
    end
  endtask

  // ------------------------------------------------------------
  // AXI4-Lite master
  // ------------------------------------------------------------
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold, output logic [1:0] resp);
    @(negedge clk);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    if (!wready) report_error("wready not raised together with awready");
    // Taken on the next rising edge
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    for (int i = 0; i < hold; i++) begin
      if (!bvalid) report_error("bvalid dropped while bready was held low");
      @(negedge clk);
    end
    if (!bvalid) report_error("the write got no response");
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
    if (bvalid) report_error("bvalid stayed high after bready");
  endtask

  task automatic axi_read(input logic [3:0] addr, input int hold,
                          output logic [31:0] data, output logic [1:0] resp);
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    for (int i = 0; i < hold; i++) begin
      if (!rvalid) report_error("rvalid dropped while rready was held low");
      @(negedge clk);
    end
    if (!rvalid) report_error("the read got no response");
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    if (rvalid) report_error("rvalid stayed high after rready");
  endtask

  task automatic pulse_src_vsync();
    @(negedge clk);
    src_vsync = 1'b1;
    @(negedge clk);
    src_vsync = 1'b0;
    vsync_edges++;
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic check_sync_frame();
    logic hs_prev;
    logic vs_prev;
    int   h_fall;
    int   h_falls;
    int   vs_low;
    wait_vsync_edge(1'b0);
    hs_prev = vga_hsync;
    vs_prev = vga_vsync;
    h_fall  = -1;
    h_falls = 0;
    vs_low  = 1;
    for (int i = 1; i <= frame_cycles; i++) begin
      @(negedge clk);
      if (hs_prev && !vga_hsync) begin
        if (h_fall >= 0 && i - h_fall != int'(h_total)) begin
          report_error($sformatf("hsync period %0d cycles", i - h_fall));
        end
        h_fall = i;
        h_falls++;
      end
      if (!hs_prev && vga_hsync && h_fall >= 0 && i - h_fall != int'(h_sync)) begin
        report_error($sformatf("hsync pulse %0d cycles", i - h_fall));
      end
      if (vs_prev && !vga_vsync && i != frame_cycles) begin
        report_error($sformatf("vsync fell %0d cycles into the frame", i));
      end
      if (i == frame_cycles && !(vs_prev && !vga_vsync)) report_error("vsync period wrong");
      if (i < frame_cycles && !vga_vsync) vs_low++;
      hs_prev = vga_hsync;
      vs_prev = vga_vsync;
    end
    if (vs_low != int'(h_total) * int'(v_sync)) report_error($sformatf("vsync low %0d", vs_low));
    if (h_falls != int'(v_total)) report_error($sformatf("%0d hsync pulses", h_falls));
  endtask

  task automatic run_line_test(input test_vec_t vec);
    logic [1:0] resp;
    axi_write(reg_ctrl_addr, {24'd0, vec.ctrl}, 4'hf, 0, resp);
    if (resp != axil_resp_okay) report_error($sformatf("control write resp %0d", resp));
    write_line(vec.pattern);
    src_vblank = vec.vblank;
    wait_line(int'(vec.line));
    check_line(vec.rule);
    src_vblank = 1'b0;
  endtask

  task automatic run_reg_test();
    logic [1:0]  resp;
    logic [31:0] data;
    logic [7:0]  val;
    val = 8'($urandom_range(0, 255));
    axi_write(reg_ctrl_addr, {24'd0, val}, 4'h1, $urandom_range(0, 12), resp);
    if (resp != axil_resp_okay) report_error($sformatf("control write resp %0d", resp));
    axi_read(reg_ctrl_addr, $urandom_range(0, 12), data, resp);
    if (resp != axil_resp_okay || data != {24'd0, val}) begin
      report_error($sformatf("control read %h resp %0d, want %h", data, resp, val));
    end
    // Byte 0 strobe low leaves the register unchanged
    axi_write(reg_ctrl_addr, {24'd0, ~val}, 4'he, 0, resp);
    axi_read(reg_ctrl_addr, 0, data, resp);
    if (data != {24'd0, val}) report_error($sformatf("strobed write changed ctrl to %h", data));
    axi_write(reg_status_addr, 32'hff, 4'hf, 0, resp);
    if (resp != axil_resp_okay) report_error($sformatf("status write resp %0d", resp));
    for (int k = 0; k < 5; k++) begin
      pulse_src_vsync();
      axi_read(reg_status_addr, 0, data, resp);
      if (resp != axil_resp_okay || data != {29'd0, expected_phase(vsync_edges)}) begin
        report_error($sformatf("phase %h after %0d frames", data, vsync_edges));
      end
    end
    axi_read(4'h8, $urandom_range(1, 8), data, resp);
    if (resp != axil_resp_slverr) report_error($sformatf("unmapped read resp %0d", resp));
    axi_write(reg_ctrl_addr, 32'h3, 4'hf, 0, resp);
  endtask

  task automatic run_stall_test();
    wait_line(int'(stall_line));
    // Column 0 on the outputs, the scan position is on stall_line now
    repeat (line_lead) @(negedge clk);
    for (int i = 0; i < num_stall; i++) begin
      src_ypos = stall_ypos[i];
      @(negedge clk);
      if (src_stall !== stall_want[i]) begin
        report_error($sformatf("src_stall %b for ypos %0d, want %b", src_stall, src_ypos,
                               stall_want[i]));
      end
    end
    src_ypos = '0;
  endtask

  function automatic string kind_name(input logic [1:0] kind);
    case (kind)
      kind_sync: return "sync";
      kind_line: return "line";
      kind_regs: return "registers";
      default:   return "stall";
    endcase
  endfunction

  initial begin
    test_vec_t vec;
    int        first;
    src_xpos    = '0;
    src_ypos    = '0;
    src_pixel   = '0;
    src_valid   = 1'b0;
    src_vblank  = 1'b0;
    src_vsync   = 1'b0;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    errors      = 0;
    tests_ok    = 0;
    tests_bad   = 0;
    vsync_edges = 0;
    void'($urandom(32'h9ed6_d5a1));
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    // Reset values before release
    if (awready || wready || arready || bvalid || rvalid) report_error("AXI not idle in reset");
    if (!vga_hsync || !vga_vsync || {vga_r, vga_g, vga_b} != 6'd0) begin
      report_error("VGA outputs not at their reset values");
    end
    rst_n = 1'b1;

    for (int t = 0; t < num_tests; t++) begin
      vec   = test_table[t];
      first = errors;
      case (vec.kind)
        kind_sync: check_sync_frame();
        kind_line: run_line_test(vec);
        kind_regs: run_reg_test();
        default:   run_stall_test();
      endcase
      if (errors == first) tests_ok++;
      else tests_bad++;
      $display("test %0d (%s) done, %0d errors", t, kind_name(vec.kind), errors - first);
    end
    $display("tests run %0d, clean %0d, with errors %0d, total errors %0d",
             num_tests, tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+verif
hdl/vga_timing_pkg.sv
hdl/video_color_pkg.sv
hdl/vga_pos_if.sv
hdl/vga_timing.sv
hdl/scan_line_buffer.sv
hdl/ntsc_palette.sv
hdl/pwm_dither.sv
hdl/video_ctrl_regs.sv
hdl/atari_vga_bridge.sv
verif/tb_atari_vga_bridge.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -Wno-fatal -f all.f --top-module tb_atari_vga_bridge -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
